// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -Wno-fatal
TOP       = tb_mac_glue
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_mac_glue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mac_glue;

  localparam int clk_period  = 4;
  localparam int rand_reads  = 40;    // Per overlay setting
  localparam int reg_writes  = 30;
  localparam int num_frames  = 60;
  localparam int max_t2      = 8;
  localparam int bus_cycles  = 3 * (rand_reads + 3) + 2 * reg_writes + 3 * num_frames + 80;
  localparam int limit_cycles = 10 + bus_cycles * 8 + num_frames * 8 + (max_t2 + 2) * 32;

  logic clk_cpu, reset, bus_req, vsync;
  mac_pkg::cpu_bus_t  bus;
  mac_pkg::mem_port_t mem;
  logic        bus_ack;
  logic [15:0] rdata;
  logic [15:0] mem_rdata = 16'h0000;
  logic [2:0]  ipl;

  // Reference model of the VIA registers
  logic [7:0]  m_port_a, m_port_b, m_sr, m_acr;
  logic        m_ddr_b0;
  logic [6:0]  m_ifr, m_ier;
  logic [15:0] m_t2;
  logic        m_t2_known;               // Count is frozen only when idle
  logic [31:0] rnd_state = 32'h2b20;

  // Values handed to the compare process
  event               cycle_done;
  logic               chk_rdata;
  logic [15:0]        got_rdata, exp_rdata;
  mac_pkg::mem_port_t got_mem, exp_mem;
  logic [2:0]         got_ipl, exp_ipl;

  mac_glue_top mac_glue_top_inst (
    .clk_cpu (clk_cpu), .reset (reset), .bus_req (bus_req), .bus (bus),
    .bus_ack (bus_ack), .rdata (rdata), .vsync (vsync), .mem (mem),
    .mem_rdata (mem_rdata), .ipl (ipl)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #(clk_period / 2) clk_cpu = ~clk_cpu;
  end

  // Memory answers with its inverted low address bits
  always @(posedge clk_cpu) mem_rdata <= ~mem.addr[15:0];

  initial begin
    #(2 * limit_cycles * clk_period);
    $display("watchdog: simulation ran past its time limit");
    stop_with_failure("run did not finish in time");
  end

  // ========================================
  // Helpers
  // ========================================
  task automatic stop_with_failure(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s = %h, expected %h", name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
    return rnd_state;
  endfunction

  function automatic logic [23:0] via_addr(input logic [3:0] idx);
    return 24'hefe1fe | ({20'h0, idx} << 9);   // Index on bits 12:9
  endfunction

  // {ram, rom} for a byte address
  function automatic logic [1:0] mem_select(input logic [23:0] addr);
    logic ovl;
    ovl = !m_port_a[4];
    casez (addr[23:20])
      4'b00??: return ovl ? 2'b10 : 2'b01;
      4'b0100: return addr[17] ? 2'b00 : 2'b01;
      4'b0110: return ovl ? 2'b00 : 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  function automatic logic [23:0] reloc_addr(input logic [23:0] addr);
    return m_port_a[4] ? addr - 24'h600000 : addr;   // Overlay means no offset
  endfunction

  function automatic logic [7:0] via_byte(input logic [3:0] idx);
    case (idx)
      4'h0: return m_port_b;
      4'h2: return {7'b1000011, m_ddr_b0};
      4'h3: return 8'h7f;
      4'h8: return m_t2[7:0];
      4'h9: return m_t2[15:8];
      4'ha: return m_sr;
      4'hb: return m_acr;
      4'hc: return 8'h00;
      4'hd: return {|(m_ifr & m_ier), m_ifr};
      4'he: return {1'b0, m_ier};
      4'hf: return m_port_a;
      default: return 8'hbe;                       // Timer 1 and index 1
    endcase
  endfunction

  function automatic logic [15:0] expected_rdata(input logic [23:0] addr);
    logic [23:0] ra;
    ra = reloc_addr(addr);
    if (addr[23:20] == 4'he) return {via_byte(addr[12:9]), 8'hef};
    else if (addr == 24'hdffdfe) return 16'h1f1f;
    else if (addr[23]) return 16'h0000;
    else if (mem_select(addr) != 2'b00) return ~ra[15:0];
    else return 16'h0000;
  endfunction

  // Register and flag effects of one access
  task automatic model_update(input logic [23:0] addr, input logic rw, input logic [7:0] d);
    if (addr[23:20] == 4'he && !rw) begin
      case (addr[12:9])
        4'h0: m_port_b = d;
        4'h2: m_ddr_b0 = d[0];
        4'h9: begin
          m_ifr[5]   = 1'b0;
          m_t2_known = 1'b0;                       // Timer now counting
        end
        4'ha: begin
          m_sr = d;
          if (m_acr[4:2] == 3'b111) m_ifr[2] = 1'b1;
        end
        4'hb: m_acr = d;
        4'hd: m_ifr = m_ifr & ~d[6:0];
        4'he: m_ier = d[7] ? (m_ier | d[6:0]) : (m_ier & ~d[6:0]);
        4'hf: m_port_a = d;
        default: ;
      endcase
    end else if (addr[23:20] == 4'he) begin
      case (addr[12:9])
        4'h0: m_ifr[4:3] = 2'b00;
        4'h8: m_ifr[5] = 1'b0;
        4'ha: m_ifr[2] = 1'b0;
        4'hf: m_ifr[1:0] = 2'b00;
        default: ;
      endcase
    end
  endtask

  // One four-phase cycle, chk enables the read data compare
  task automatic bus_cycle(input logic [23:0] addr, input logic rw, input logic [7:0] d,
                           input logic chk);
    int   edges;
    logic ack_seen;
    logic [1:0] cs;
    cs        = mem_select(addr);
    exp_rdata = expected_rdata(addr);
    exp_mem   = '{ram_cs: cs[1], rom_cs: cs[0], we: cs[1] && !rw, addr: reloc_addr(addr)};
    chk_rdata = chk && rw && !(addr[23:20] == 4'he && addr[12:10] == 3'b100 && !m_t2_known);
    @(posedge clk_cpu);
    bus_req <= 1'b1;
    bus     <= '{addr: addr[23:1], rw: rw, uds_n: 1'b0, lds_n: 1'b0, wdata: {d, 8'h00}};
    edges    = 0;
    ack_seen = 1'b0;
    while (!ack_seen && edges < 8) begin
      @(posedge clk_cpu);
      edges++;
      @(negedge clk_cpu);
      if (edges == 1) got_mem = mem;             // Strobe cycle
      ack_seen = bus_ack;
    end
    if (!ack_seen) stop_with_failure("bus_ack never rose after bus_req");
    check_value("bus_ack latency", edges, 2);
    got_rdata = rdata;
    model_update(addr, rw, d);
    got_ipl = ipl;
    exp_ipl = |(m_ifr & m_ier) ? mac_pkg::ipl_via : mac_pkg::ipl_none;
    -> cycle_done;
    @(posedge clk_cpu);
    bus_req <= 1'b0;
    edges = 0;
    @(negedge clk_cpu);
    while (bus_ack && edges < 8) begin
      @(negedge clk_cpu);
      edges++;
    end
    if (bus_ack) stop_with_failure("bus_ack stuck high after bus_req fell");
  endtask

  // Compare process
  always @(cycle_done) begin
    if (chk_rdata) check_value("rdata", got_rdata, exp_rdata);
    check_value("mem.ram_cs", got_mem.ram_cs, exp_mem.ram_cs);
    check_value("mem.rom_cs", got_mem.rom_cs, exp_mem.rom_cs);
    check_value("mem.we", got_mem.we, exp_mem.we);
    check_value("mem.addr", got_mem.addr, exp_mem.addr);
    check_value("ipl", got_ipl, exp_ipl);
  end

  task automatic vsync_frame();
    @(posedge clk_cpu);
    vsync <= 1'b1;
    repeat (3) @(posedge clk_cpu);
    vsync <= 1'b0;                               // Falling edge marks vblank
    repeat (4) @(posedge clk_cpu);
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [31:0] r;
    logic [23:0] a;
    logic [15:0] t2_start;
    int          t0;
    reset = 1'b1;
    bus_req = 1'b0;
    bus = '0;
    vsync = 1'b0;
    {m_port_a, m_port_b, m_ddr_b0} = {8'h7f, 8'hff, 1'b1};
    {m_sr, m_acr, m_ifr, m_ier} = '0;
    m_t2 = 16'h0000;
    m_t2_known = 1'b1;
    repeat (10) @(posedge clk_cpu);
    reset <= 1'b0;

    // Decode and relocation, overlay off then on then off
    for (int pass = 0; pass < 3; pass++) begin
      if (pass > 0) bus_cycle(via_addr(4'hf), 1'b0, (pass == 1) ? 8'h6f : 8'h7f, 1'b0);
      // Writes in low memory and at the RAM base, only RAM gets mem.we
      r = lcg_next();
      bus_cycle({4'h0, r[19:1], 1'b0}, 1'b0, r[27:20], 1'b0);
      bus_cycle({4'h6, r[19:1], 1'b0}, 1'b0, r[27:20], 1'b0);
      for (int i = 0; i < rand_reads; i++) begin
        r = lcg_next();
        a = (r[30:28] == 3'd0) ? 24'hdffdfe : {r[23:1], 1'b0};
        bus_cycle(a, 1'b1, 8'h00, 1'b1);
      end
    end

    // Register readback
    for (int i = 0; i < reg_writes; i++) begin
      r = lcg_next();
      case (r[18:16])
        3'd0, 3'd1: a = via_addr(4'h0);
        3'd2:       a = via_addr(4'h2);
        3'd3:       a = via_addr(4'hb);
        3'd4, 3'd5: a = via_addr(4'ha);
        default:    a = via_addr(4'hf);
      endcase
      bus_cycle(a, 1'b0, r[27:20], 1'b0);
      bus_cycle(a, 1'b1, 8'h00, 1'b1);
    end
    for (int idx = 1; idx < 8; idx++) bus_cycle(via_addr(4'(idx)), 1'b1, 8'h00, 1'b1);
    bus_cycle(via_addr(4'hc), 1'b1, 8'h00, 1'b1);

    // Keyboard ready interrupt
    bus_cycle(via_addr(4'hb), 1'b0, 8'h1c, 1'b0);   // SR out mode
    bus_cycle(via_addr(4'ha), 1'b0, 8'h5a, 1'b0);
    bus_cycle(via_addr(4'he), 1'b0, 8'h84, 1'b0);
    bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);
    check_value("ipl", ipl, mac_pkg::ipl_via);
    bus_cycle(via_addr(4'ha), 1'b1, 8'h00, 1'b1);   // Read acks keyready
    check_value("ipl", ipl, mac_pkg::ipl_none);
    bus_cycle(via_addr(4'ha), 1'b0, 8'ha5, 1'b0);
    bus_cycle(via_addr(4'hd), 1'b0, 8'h04, 1'b0);   // Clear by write
    bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);
    bus_cycle(via_addr(4'he), 1'b0, 8'h04, 1'b0);
    bus_cycle(via_addr(4'he), 1'b1, 8'h00, 1'b1);

    // Vertical blank and one second
    for (int f = 1; f <= num_frames; f++) begin
      vsync_frame();
      m_ifr[1] = 1'b1;
      if (f == num_frames) m_ifr[0] = 1'b1;
      bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);
      bus_cycle(via_addr(4'hf), 1'b1, 8'h00, 1'b1);
      bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);
    end

    // Timer 2 one shot
    r = lcg_next();
    t2_start = {13'h0, r[22:20]} + 16'd1;
    bus_cycle(via_addr(4'h8), 1'b0, t2_start[7:0], 1'b0);
    bus_cycle(via_addr(4'h9), 1'b0, 8'h00, 1'b0);
    t0 = $time;
    bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);   // Not fired yet
    got_rdata = 16'h0000;
    while (!got_rdata[13]) begin
      if ($time - t0 > (t2_start + 2) * 32 * clk_period)
        stop_with_failure("timer 2 flag never set");
      bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b0);
    end
    // Count ticks must elapse before the flag
    if ($time - t0 < t2_start * 32 * clk_period)
      stop_with_failure("timer 2 flag set before its count ran out");
    m_ifr[5] = 1'b1;
    m_t2 = 16'h0000;                                // Stops at zero
    m_t2_known = 1'b1;
    bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);
    bus_cycle(via_addr(4'h8), 1'b1, 8'h00, 1'b1);
    bus_cycle(via_addr(4'h9), 1'b1, 8'h00, 1'b1);
    bus_cycle(via_addr(4'hd), 1'b1, 8'h00, 1'b1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module addr_decode (
  input  wire [23:1]           bus_addr,
  input  wire                  overlay,
  output mac_pkg::chip_sel_t   sel,
  output logic [23:0]          mem_addr
);

  logic [23:0] start_ram;

  // ROM mirrored over low memory until overlay bit changes
  always_comb begin
    sel = '0;
    casez (bus_addr[23:20])
      4'b00??: begin
        if (overlay) sel.ram = 1'b1;
        else sel.rom = 1'b1;
      end
      4'b0100: if (!bus_addr[17]) sel.rom = 1'b1;
      4'b0101: if (bus_addr[19:12] == 8'h80) sel.scsi = 1'b1;
      4'b0110: if (!overlay) sel.ram = 1'b1;  // RAM at its normal base
      4'b10?1: sel.scc = 1'b1;
      4'b1101: sel.iwm = 1'b1;
      4'b1110: sel.via = 1'b1;
      default: sel = '0;
    endcase
  end

  // Relocate so RAM always starts at zero in the memory port
  assign start_ram = overlay ? 24'h000000 : mac_pkg::ram_base_normal;
  assign mem_addr  = {bus_addr, 1'b0} - start_ram;

endmodule

`default_nettype wire

// File: src/bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl (
  input  wire                    clk_cpu,
  input  wire                    reset,
  input  wire                    bus_req,
  input  wire mac_pkg::cpu_bus_t bus,
  output logic                   bus_ack,
  output logic [15:0]            rdata,
  input  wire mac_pkg::chip_sel_t sel,
  output logic                   mem_we,
  output mac_pkg::via_access_t   via_acc,
  input  wire [7:0]              via_rdata,
  input  wire [15:0]             mem_rdata
);

  mac_pkg::bus_state_e state;
  logic        strobe;       // High for the single access cycle
  logic        via_hit;
  logic [23:0] byte_addr;

  assign byte_addr = {bus.addr, 1'b0};
  assign strobe    = (state == mac_pkg::st_access);
  assign via_hit   = sel.via && !bus.uds_n;   // VIA sits on the upper byte lane

  // ======================================
  // Handshake FSM
  // ======================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state <= mac_pkg::st_idle;
    end else begin
      case (state)
        mac_pkg::st_idle:    if (bus_req) state <= mac_pkg::st_access;
        mac_pkg::st_access:  state <= mac_pkg::st_ack;
        mac_pkg::st_ack:     if (!bus_req) state <= mac_pkg::st_release;
        mac_pkg::st_release: state <= mac_pkg::st_idle;  // Ack drops here
        default:             state <= mac_pkg::st_idle;
      endcase
    end
  end

  // Ack spans the wait and the release cycle
  assign bus_ack = (state == mac_pkg::st_ack) || (state == mac_pkg::st_release);

  // ======================================
  // Access strobes
  // ======================================
  always_comb begin
    via_acc.wr   = strobe && via_hit && !bus.rw;
    via_acc.rd   = strobe && via_hit && bus.rw;
    via_acc.idx  = mac_pkg::via_reg_e'(bus.addr[12:9]);  // Index drives read mux always
    via_acc.data = bus.wdata[15:8];
  end

  assign mem_we = strobe && sel.ram && !bus.rw;  // RAM write pulse

  // ======================================
  // Read data capture
  // ======================================

  // Sampled on the strobe edge, before VIA side effects land
  always_ff @(posedge clk_cpu) begin
    if (strobe) begin
      if (sel.via)
        rdata <= {via_rdata, mac_pkg::via_low_byte};
      else if (byte_addr == mac_pkg::iwm_hack_addr)
        rdata <= mac_pkg::iwm_hack_data;  // Floppy status stand-in
      else if (bus.addr[23])
        rdata <= 16'h0000;                // Other I/O space
      else if (sel.ram || sel.rom)
        rdata <= mem_rdata;
      else
        rdata <= 16'h0000;
    end
  end

endmodule

`default_nettype wire

// File: src/mac_glue_top.sv
`timescale 1ns/1ns
`default_nettype none

module mac_glue_top (
  input  wire                  clk_cpu,
  input  wire                  reset,
  // CPU side
  input  wire                  bus_req,
  input  wire mac_pkg::cpu_bus_t bus,
  output logic                 bus_ack,
  output logic [15:0]          rdata,
  // Video timing
  input  wire                  vsync,
  // External memory
  output mac_pkg::mem_port_t   mem,
  input  wire [15:0]           mem_rdata,
  output logic [2:0]           ipl
);

  mac_pkg::chip_sel_t   sel;
  mac_pkg::via_access_t via_acc;
  logic [23:0] mem_addr;
  logic        mem_we;
  logic [7:0]  via_rdata;
  logic        overlay;
  logic        t2_load, t2_fire;
  logic [15:0] t2_count;          // Load value into timer 2
  logic [15:0] t2_value;          // Running count back to the VIA
  logic        vblank_pulse, onesec_pulse;

  // ======================================
  // Bus side
  // ======================================
  bus_ctrl bus_ctrl_inst (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus       (bus),
    .bus_ack   (bus_ack),
    .rdata     (rdata),
    .sel       (sel),
    .mem_we    (mem_we),
    .via_acc   (via_acc),
    .via_rdata (via_rdata),
    .mem_rdata (mem_rdata)
  );

  addr_decode addr_decode_inst (
    .bus_addr (bus.addr),
    .overlay  (overlay),
    .sel      (sel),
    .mem_addr (mem_addr)
  );

  // Memory port gathered from decode and strobe
  assign mem = '{ram_cs: sel.ram, rom_cs: sel.rom, we: mem_we, addr: mem_addr};

  // ======================================
  // VIA and its timers
  // ======================================
  via_regs via_regs_inst (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .acc          (via_acc),
    .rdata        (via_rdata),
    .overlay      (overlay),
    .t2_load      (t2_load),
    .t2_count     (t2_count),
    .t2_value     (t2_value),
    .t2_fire      (t2_fire),
    .vblank_pulse (vblank_pulse),
    .onesec_pulse (onesec_pulse),
    .ipl          (ipl)
  );

  via_timer2 via_timer2_inst (
    .clk_cpu    (clk_cpu),
    .reset      (reset),
    .load       (t2_load),
    .load_value (t2_count),
    .count      (t2_value),
    .fire       (t2_fire)
  );

  vblank_timer vblank_timer_inst (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .vsync        (vsync),
    .vblank_pulse (vblank_pulse),
    .onesec_pulse (onesec_pulse)
  );

endmodule

`default_nettype wire

// File: src/mac_pkg.sv
`default_nettype none

package mac_pkg;

  // ======================================
  // Enums
  // ======================================

  // VIA register index, CPU address bits 12:9
  typedef enum logic [3:0] {
    reg_port_b = 4'h0,
    reg_ddr_b  = 4'h2,
    reg_ddr_a  = 4'h3,
    reg_t1c_lo = 4'h4,
    reg_t1c_hi = 4'h5,
    reg_t1l_lo = 4'h6,
    reg_t1l_hi = 4'h7,
    reg_t2_lo  = 4'h8,
    reg_t2_hi  = 4'h9,
    reg_sr     = 4'ha,
    reg_acr    = 4'hb,
    reg_pcr    = 4'hc,
    reg_ifr    = 4'hd,
    reg_ier    = 4'he,
    reg_port_a = 4'hf
  } via_reg_e;

  // Bit positions in IFR and IER
  typedef enum logic [2:0] {
    int_onesec   = 3'd0,
    int_vblank   = 3'd1,
    int_keyready = 3'd2,
    int_keybit   = 3'd3,
    int_keyclk   = 3'd4,
    int_t2       = 3'd5,
    int_t1       = 3'd6
  } int_bit_e;

  typedef enum logic [1:0] {
    st_idle,    // Waiting for bus_req
    st_access,  // Strobe cycle
    st_ack,     // Holding bus_ack until req drops
    st_release  // Last cycle of bus_ack
  } bus_state_e;

  // ======================================
  // Bus structs
  // ======================================

  typedef struct packed {
    logic [23:1] addr;   // Word address
    logic        rw;     // 1 = read
    logic        uds_n;
    logic        lds_n;
    logic [15:0] wdata;
  } cpu_bus_t;

  typedef struct packed {
    logic ram;
    logic rom;
    logic scsi;
    logic scc;
    logic iwm;
    logic via;
  } chip_sel_t;

  typedef struct packed {
    logic        ram_cs;
    logic        rom_cs;
    logic        we;
    logic [23:0] addr;   // Relocated byte address
  } mem_port_t;

  typedef struct packed {
    logic     wr;
    logic     rd;
    via_reg_e idx;
    logic [7:0] data;    // Upper data byte from CPU
  } via_access_t;

  // ======================================
  // Constants
  // ======================================

  // Address map
  localparam logic [23:0] ram_base_normal = 24'h600000;
  localparam logic [23:0] iwm_hack_addr   = 24'hdffdfe;
  localparam logic [15:0] iwm_hack_data   = 16'h1f1f;
  localparam logic [7:0]  via_low_byte    = 8'hef;
  localparam logic [7:0]  via_unmapped    = 8'hbe;

  // VIA fixed values and ACR shift modes
  localparam logic [7:0] ddr_a_value     = 8'h7f;
  localparam logic [6:0] ddr_b_fixed     = 7'b1000011;
  localparam logic [2:0] acr_sr_out_mode = 3'b111;
  localparam logic [2:0] acr_sr_in_mode  = 3'b011;
  localparam logic [7:0] port_a_reset    = 8'h7f;
  localparam logic [7:0] port_b_reset    = 8'hff;

  // Timers
  localparam int prescale_bits  = 5;    // 32 cycle prescale
  localparam int frames_per_sec = 60;

  // Interrupt priority levels, active low encoding
  localparam logic [2:0] ipl_via  = 3'b110;
  localparam logic [2:0] ipl_none = 3'b111;

endpackage

`default_nettype wire

// File: src/vblank_timer.sv
`timescale 1ns/1ns
`default_nettype none

module vblank_timer (
  input  wire  clk_cpu,
  input  wire  reset,
  input  wire  vsync,
  output logic vblank_pulse,
  output logic onesec_pulse
);

  logic       vsync_q;
  logic       vsync_fall;
  logic [5:0] frame_cnt;        // Frames within the current second

  assign vsync_fall = vsync_q && !vsync;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q      <= 1'b0;
      frame_cnt    <= 6'd0;
      vblank_pulse <= 1'b0;
      onesec_pulse <= 1'b0;
    end else begin
      vsync_q      <= vsync;
      vblank_pulse <= vsync_fall;
      onesec_pulse <= 1'b0;
      if (vsync_fall) begin
        if (frame_cnt == 6'(mac_pkg::frames_per_sec - 1)) begin
          frame_cnt    <= 6'd0;   // Wrap each second
          onesec_pulse <= 1'b1;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/via_regs.sv
`timescale 1ns/1ns
`default_nettype none

module via_regs (
  input  wire                      clk_cpu,
  input  wire                      reset,
  input  wire mac_pkg::via_access_t acc,
  output logic [7:0]               rdata,
  output logic                     overlay,
  output logic                     t2_load,
  output logic [15:0]              t2_count,
  input  wire [15:0]               t2_value,
  input  wire                      t2_fire,
  input  wire                      vblank_pulse,
  input  wire                      onesec_pulse,
  output logic [2:0]               ipl
);

  logic [7:0] port_a, port_b;
  logic       ddr_b0;          // Only bit 0 of DDR B is writable
  logic [7:0] t2_latch_lo;
  logic [7:0] sr, acr;
  logic [6:0] ifr, ier;
  logic       irq;

  assign irq     = |(ifr & ier);
  assign overlay = !port_a[4];
  assign ipl     = irq ? mac_pkg::ipl_via : mac_pkg::ipl_none;

  // Timer 2 loads on the high byte write
  assign t2_load  = acc.wr && (acc.idx == mac_pkg::reg_t2_hi);
  assign t2_count = {acc.data, t2_latch_lo};

  // ======================================
  // Register writes and flag updates
  // ======================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      port_a      <= mac_pkg::port_a_reset;
      port_b      <= mac_pkg::port_b_reset;
      ddr_b0      <= 1'b1;
      t2_latch_lo <= 8'h00;
      sr          <= 8'h00;
      acr         <= 8'h00;
      ifr         <= 7'h00;
      ier         <= 7'h00;
    end else begin
      if (acc.wr) begin
        case (acc.idx)
          mac_pkg::reg_port_b: port_b <= acc.data;
          mac_pkg::reg_ddr_b:  ddr_b0 <= acc.data[0];
          mac_pkg::reg_t2_lo:  t2_latch_lo <= acc.data;   // Latched until high write
          mac_pkg::reg_t2_hi:  ifr[mac_pkg::int_t2] <= 1'b0;
          mac_pkg::reg_sr: begin
            sr <= acc.data;
            // Shift out to the keyboard counts as done at once
            if (acr[4:2] == mac_pkg::acr_sr_out_mode) ifr[mac_pkg::int_keyready] <= 1'b1;
          end
          mac_pkg::reg_acr:    acr <= acc.data;
          mac_pkg::reg_ifr:    ifr <= ifr & ~acc.data[6:0];  // Write 1 to clear
          mac_pkg::reg_ier: begin
            if (acc.data[7]) ier <= ier | acc.data[6:0];      // Set mode
            else ier <= ier & ~acc.data[6:0];                 // Clear mode
          end
          mac_pkg::reg_port_a: port_a <= acc.data;
          default: ;
        endcase
      end else if (acc.rd) begin
        // Reads that acknowledge interrupts
        case (acc.idx)
          mac_pkg::reg_port_b: begin
            ifr[mac_pkg::int_keyclk] <= 1'b0;
            ifr[mac_pkg::int_keybit] <= 1'b0;
          end
          mac_pkg::reg_t2_lo: ifr[mac_pkg::int_t2] <= 1'b0;
          mac_pkg::reg_sr:    ifr[mac_pkg::int_keyready] <= 1'b0;
          mac_pkg::reg_port_a: begin
            ifr[mac_pkg::int_onesec] <= 1'b0;
            ifr[mac_pkg::int_vblank] <= 1'b0;
          end
          default: ;
        endcase
      end

      // Event sets win over read clears
      if (vblank_pulse) ifr[mac_pkg::int_vblank] <= 1'b1;
      if (onesec_pulse) ifr[mac_pkg::int_onesec] <= 1'b1;
      if (t2_fire && !t2_load) ifr[mac_pkg::int_t2] <= 1'b1;  // Reload cancels
    end
  end

  // ======================================
  // Register read mux
  // ======================================
  always_comb begin
    case (acc.idx)
      mac_pkg::reg_port_b: rdata = port_b;
      mac_pkg::reg_ddr_b:  rdata = {mac_pkg::ddr_b_fixed, ddr_b0};
      mac_pkg::reg_ddr_a:  rdata = mac_pkg::ddr_a_value;
      mac_pkg::reg_t1c_lo,
      mac_pkg::reg_t1c_hi,
      mac_pkg::reg_t1l_lo,
      mac_pkg::reg_t1l_hi: rdata = mac_pkg::via_unmapped;  // No timer 1
      mac_pkg::reg_t2_lo:  rdata = t2_value[7:0];
      mac_pkg::reg_t2_hi:  rdata = t2_value[15:8];
      mac_pkg::reg_sr:     rdata = sr;
      mac_pkg::reg_acr:    rdata = acr;
      mac_pkg::reg_pcr:    rdata = 8'h00;
      mac_pkg::reg_ifr:    rdata = {irq, ifr};              // Bit 7 is any enabled
      mac_pkg::reg_ier:    rdata = {1'b0, ier};
      mac_pkg::reg_port_a: rdata = port_a;
      default:             rdata = mac_pkg::via_unmapped;
    endcase
  end

endmodule

`default_nettype wire

// File: src/via_timer2.sv
`timescale 1ns/1ns
`default_nettype none

module via_timer2 (
  input  wire        clk_cpu,
  input  wire        reset,
  input  wire        load,
  input  wire [15:0] load_value,
  output logic [15:0] count,
  output logic       fire
);

  logic [mac_pkg::prescale_bits-1:0] prescale;
  logic tick;
  logic armed;                  // One shot, cleared after firing

  assign tick = (prescale == '0);

  // Free-running divider, approximates the VIA clock
  always_ff @(posedge clk_cpu) begin
    if (reset) prescale <= '0;
    else prescale <= prescale + 1'b1;
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      count <= 16'h0000;
      armed <= 1'b0;
      fire  <= 1'b0;
    end else begin
      fire <= 1'b0;
      if (load) begin
        count <= load_value;
        armed <= 1'b1;
      end else if (tick && armed) begin
        if (count == 16'h0000) begin
          fire  <= 1'b1;
          armed <= 1'b0;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
src/mac_pkg.sv
src/addr_decode.sv
src/bus_ctrl.sv
src/via_regs.sv
src/via_timer2.sv
src/vblank_timer.sv
src/mac_glue_top.sv
dv/tb_mac_glue.sv
